// File: mera_pkg.sv
package mera_pkg;

	// ----------------------------------------
	// machine word and sizes
	// ----------------------------------------
	typedef logic [15:0] word_t;

	// clock cycles per serial bit
	localparam int UART_DIV = 8;
	localparam int UART_CW = $clog2(UART_DIV);

	// power-up off phase, clear pulse length
	localparam int OFF_CYCLES = 16;
	localparam int CLR_CYCLES = 4;

	localparam int MEM_WORDS = 256;
	localparam int MEM_AW = $clog2(MEM_WORDS);
	// sequencer counter must hold the memory sweep
	localparam int SEQ_CW = MEM_AW;

	// ----------------------------------------
	// register select codes
	// ----------------------------------------
	localparam logic [3:0] REG_R0 = 4'd0;
	localparam logic [3:0] REG_R1 = 4'd1;
	localparam logic [3:0] REG_R2 = 4'd2;
	localparam logic [3:0] REG_R3 = 4'd3;
	localparam logic [3:0] REG_R4 = 4'd4;
	localparam logic [3:0] REG_R5 = 4'd5;
	localparam logic [3:0] REG_R6 = 4'd6;
	localparam logic [3:0] REG_R7 = 4'd7;
	localparam logic [3:0] REG_IC = 4'd8;
	localparam logic [3:0] REG_AR = 4'd9;

	// panel opcodes, ascii letters on the serial line
	typedef enum logic [7:0] {
		OP_KEYS   = 8'h4B,
		OP_SELECT = 8'h53,
		OP_LOAD   = 8'h4C,
		OP_STORE  = 8'h57,
		OP_FETCH  = 8'h46,
		OP_STEP   = 8'h4E,
		OP_CLEAR  = 8'h43,
		OP_READ   = 8'h52
	} panel_op_t;

	// power and clear sequencer
	typedef enum logic [1:0] {
		S_OFF,
		S_CLEAR_ALL,
		S_ON,
		S_CLEAR
	} seq_state_t;

endpackage

// File: panel_if.sv
`timescale 1ns/1ps

interface panel_if import mera_pkg::*; ();

	// panel side: command and its operands
	panel_op_t op;
	// one cycle, marks op as valid
	logic strobe;
	word_t keys;
	// displayed register
	logic [3:0] sel;

	// core side
	word_t w;
	// not powered or being cleared
	logic busy;

	modport panel (
		output op,
		output strobe,
		output keys,
		output sel,
		input  w,
		input  busy
	);

	modport core (
		input  op,
		input  strobe,
		input  keys,
		input  sel,
		output w,
		output busy
	);

endinterface

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx import mera_pkg::*; (
	input  logic       CLK_EXT,
	input  logic       reset,
	input  logic       rxd,
	output logic [7:0] data,
	output logic       valid
);

	logic [1:0] sync;
	logic rx_s;
	logic active;
	logic mid;
	logic [UART_CW-1:0] cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] nbit;

	assign rx_s = sync[1];
	// sample point, middle of the bit
	assign mid = active && (cnt == UART_CW'(UART_DIV / 2 - 1));

	always_ff @(posedge CLK_EXT) begin
		if (reset) begin
			// line idles high
			sync <= '1;
			active <= 1'b0;
			cnt <= '0;
			nbit <= '0;
			valid <= 1'b0;
		end else begin
			sync <= {sync[0], rxd};
			valid <= 1'b0;
			if (!active) begin
				// falling edge, start bit begins
				if (!rx_s) begin
					active <= 1'b1;
					cnt <= '0;
					nbit <= '0;
				end
			end else begin
				if (cnt == UART_CW'(UART_DIV - 1)) begin
					cnt <= '0;
					nbit <= nbit + 4'd1;
				end else begin
					cnt <= cnt + 1'b1;
				end
				// start bit gone high again, glitch
				if (mid && nbit == 4'd0 && rx_s)
					active <= 1'b0;
				// stop bit, byte done if framed
				if (mid && nbit == 4'd9) begin
					active <= 1'b0;
					valid <= rx_s;
				end
			end
		end
	end

	// lsb first
	always_ff @(posedge CLK_EXT) begin
		if (mid && nbit != 4'd0 && nbit != 4'd9)
			data <= {rx_s, data[7:1]};
	end

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx import mera_pkg::*; (
	input  logic       CLK_EXT,
	input  logic       reset,
	input  logic [7:0] data,
	input  logic       start,
	output logic       txd,
	output logic       busy
);

	// stop, data, start; shifted out from bit 0
	logic [9:0] sh;
	logic [UART_CW-1:0] cnt;
	logic [3:0] nbit;

	// ones shift in behind the frame, so idle is high
	assign txd = sh[0];

	always_ff @(posedge CLK_EXT) begin
		if (reset) begin
			sh <= '1;
			busy <= 1'b0;
			cnt <= '0;
			nbit <= '0;
		end else if (!busy) begin
			if (start) begin
				sh <= {1'b1, data, 1'b0};
				busy <= 1'b1;
				cnt <= '0;
				nbit <= '0;
			end
		end else if (cnt == UART_CW'(UART_DIV - 1)) begin
			cnt <= '0;
			sh <= {1'b1, sh[9:1]};
			// end of stop bit
			if (nbit == 4'd9)
				busy <= 1'b0;
			else
				nbit <= nbit + 4'd1;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: panel_ctrl.sv
`timescale 1ns/1ps

module panel_ctrl import mera_pkg::*; (
	input  logic   CLK_EXT,
	input  logic   reset,
	input  logic   rxd,
	output logic   txd,
	output logic   clear_req,
	panel_if.panel pif
);

	typedef enum logic [2:0] {
		P_IDLE,
		P_KEY_HI,
		P_KEY_LO,
		P_SEL,
		P_ISSUE,
		P_RD_HI,
		P_RD_LO
	} pstate_t;

	pstate_t state;
	logic [7:0] rx_data;
	logic [7:0] rx_hold;
	logic [7:0] byte_in;
	logic [7:0] lo_byte;
	logic [7:0] tx_data;
	logic rx_valid;
	logic rx_full;
	logic take;
	logic byte_ok;
	logic go;
	logic tx_start;
	logic tx_busy;

	uart_rx rx_inst (
		.CLK_EXT(CLK_EXT),
		.reset(reset),
		.rxd(rxd),
		.data(rx_data),
		.valid(rx_valid)
	);

	uart_tx tx_inst (
		.CLK_EXT(CLK_EXT),
		.reset(reset),
		.data(tx_data),
		.start(tx_start),
		.txd(txd),
		.busy(tx_busy)
	);

	// ----------------------------------------
	// byte input, one byte of slack
	// ----------------------------------------
	// states that consume bytes
	assign take = (state inside {P_IDLE, P_KEY_HI, P_KEY_LO, P_SEL});
	assign byte_ok = rx_valid || rx_full;
	// held byte is older, goes first
	assign byte_in = rx_full ? rx_hold : rx_data;

	always_ff @(posedge CLK_EXT) begin
		if (reset)
			rx_full <= 1'b0;
		else if (rx_valid && (rx_full || !take))
			rx_full <= 1'b1;
		else if (take)
			rx_full <= 1'b0;
	end

	always_ff @(posedge CLK_EXT) begin
		if (rx_valid && (rx_full || !take))
			rx_hold <= rx_data;
	end

	// ----------------------------------------
	// command issue and reply
	// ----------------------------------------
	// read also needs a free transmitter
	assign go = (state == P_ISSUE) && !pif.busy && !(pif.op == OP_READ && tx_busy);
	assign pif.strobe = go;
	// high byte straight from w, low byte captured
	assign tx_start = (state == P_RD_HI) || (state == P_RD_LO && !tx_busy);
	assign tx_data = (state == P_RD_HI) ? pif.w[15:8] : lo_byte;

	always_ff @(posedge CLK_EXT) begin
		if (state == P_RD_HI)
			lo_byte <= pif.w[7:0];
	end

	always_ff @(posedge CLK_EXT) begin
		if (reset) begin
			state <= P_IDLE;
			pif.op <= OP_KEYS;
			pif.keys <= '0;
			pif.sel <= REG_R0;
			clear_req <= 1'b0;
		end else begin
			clear_req <= 1'b0;
			case (state)
				P_IDLE: begin
					if (byte_ok) begin
						case (byte_in)
							OP_KEYS: state <= P_KEY_HI;
							OP_SELECT: state <= P_SEL;
							OP_LOAD, OP_STORE, OP_FETCH, OP_STEP, OP_READ: begin
								pif.op <= panel_op_t'(byte_in);
								state <= P_ISSUE;
							end
							OP_CLEAR: clear_req <= 1'b1;
							// unknown bytes dropped
							default: state <= P_IDLE;
						endcase
					end
				end
				P_KEY_HI: begin
					if (byte_ok) begin
						pif.keys[15:8] <= byte_in;
						state <= P_KEY_LO;
					end
				end
				P_KEY_LO: begin
					if (byte_ok) begin
						pif.keys[7:0] <= byte_in;
						state <= P_IDLE;
					end
				end
				P_SEL: begin
					if (byte_ok) begin
						pif.sel <= byte_in[3:0];
						state <= P_IDLE;
					end
				end
				// waits here while the core is busy
				P_ISSUE: begin
					if (go)
						state <= (pif.op == OP_READ) ? P_RD_HI : P_IDLE;
				end
				P_RD_HI: state <= P_RD_LO;
				P_RD_LO: begin
					if (!tx_busy)
						state <= P_IDLE;
				end
				default: state <= P_IDLE;
			endcase
		end
	end

endmodule

// File: power_seq.sv
`timescale 1ns/1ps

module power_seq import mera_pkg::*; (
	input  logic CLK_EXT,
	input  logic reset,
	input  logic clear_req,
	output logic off,
	output logic pon,
	output logic clo,
	output logic clm
);

	seq_state_t state;
	// shared by off phase and both clears
	logic [SEQ_CW-1:0] cnt;
	logic clr_ok;

	// clear source gating, only a powered machine clears
	assign clr_ok = clear_req && (state == S_ON);

	always_ff @(posedge CLK_EXT) begin
		if (reset) begin
			state <= S_OFF;
			cnt <= SEQ_CW'(OFF_CYCLES - 1);
		end else begin
			case (state)
				S_OFF: begin
					if (cnt == '0) begin
						state <= S_CLEAR_ALL;
						// one cycle per memory word
						cnt <= SEQ_CW'(MEM_WORDS - 1);
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				S_CLEAR_ALL, S_CLEAR: begin
					if (cnt == '0)
						state <= S_ON;
					else
						cnt <= cnt - 1'b1;
				end
				S_ON: begin
					if (clr_ok) begin
						state <= S_CLEAR;
						cnt <= SEQ_CW'(CLR_CYCLES - 1);
					end
				end
				default: state <= S_OFF;
			endcase
		end
	end

	// outputs decoded from state
	assign off = (state == S_OFF);
	assign clm = (state == S_CLEAR_ALL);
	assign clo = (state == S_CLEAR_ALL) || (state == S_CLEAR);
	// operator clear keeps power on
	assign pon = (state == S_ON) || (state == S_CLEAR);

endmodule

// File: cpu_core.sv
`timescale 1ns/1ps

module cpu_core import mera_pkg::*; (
	input  logic  CLK_EXT,
	input  logic  reset,
	input  logic  off,
	input  logic  clo,
	input  logic  clm,
	panel_if.core pif
);

	word_t r [8];
	word_t ic;
	word_t ar;
	word_t mem [MEM_WORDS];
	word_t mem_q;
	word_t sel_word;
	logic [MEM_AW-1:0] clr_addr;
	// fetched word on display
	logic show_mem;
	logic do_load;
	logic do_store;
	logic do_fetch;
	logic do_step;

	assign pif.busy = off | clo | clm;

	assign do_load = pif.strobe && (pif.op == OP_LOAD);
	assign do_store = pif.strobe && (pif.op == OP_STORE);
	assign do_fetch = pif.strobe && (pif.op == OP_FETCH);
	assign do_step = pif.strobe && (pif.op == OP_STEP);

	// ----------------------------------------
	// registers, clo clears all
	// ----------------------------------------
	always_ff @(posedge CLK_EXT) begin
		if (reset || clo) begin
			for (int i = 0; i < 8; i++)
				r[i] <= '0;
			ic <= '0;
			ar <= '0;
			show_mem <= 1'b0;
		end else begin
			if (do_load) begin
				// codes above 9 ignored
				if (pif.sel <= REG_R7)
					r[pif.sel[2:0]] <= pif.keys;
				else if (pif.sel == REG_IC)
					ic <= pif.keys;
				else if (pif.sel == REG_AR)
					ar <= pif.keys;
			end
			// address register post-increments
			if (do_store || do_fetch)
				ar <= ar + 16'd1;
			if (do_step)
				ic <= ic + 16'd1;
			// read leaves the display alone
			if (do_fetch)
				show_mem <= 1'b1;
			else if (do_load || do_store || do_step)
				show_mem <= 1'b0;
		end
	end

	// ----------------------------------------
	// memory and power-up sweep
	// ----------------------------------------
	always_ff @(posedge CLK_EXT) begin
		if (reset || off)
			clr_addr <= '0;
		else if (clm)
			clr_addr <= clr_addr + 1'b1;
	end

	always_ff @(posedge CLK_EXT) begin
		if (clm)
			mem[clr_addr] <= '0;
		else if (do_store)
			mem[ar[MEM_AW-1:0]] <= pif.keys;
		if (do_fetch)
			mem_q <= mem[ar[MEM_AW-1:0]];
	end

	// display mux
	always_comb begin
		case (pif.sel)
			REG_R0: sel_word = r[0];
			REG_R1: sel_word = r[1];
			REG_R2: sel_word = r[2];
			REG_R3: sel_word = r[3];
			REG_R4: sel_word = r[4];
			REG_R5: sel_word = r[5];
			REG_R6: sel_word = r[6];
			REG_R7: sel_word = r[7];
			REG_IC: sel_word = ic;
			REG_AR: sel_word = ar;
			default: sel_word = '0;
		endcase
	end

	assign pif.w = show_mem ? mem_q : sel_word;

endmodule

// File: mera_top.sv
`timescale 1ns/1ps

module mera_top (
	input  logic CLK_EXT,
	input  logic reset,
	input  logic rxd,
	output logic txd,
	output logic pon,
	output logic clo
);

	// ----------------------------------------
	// sequencer outputs, panel clear request
	// ----------------------------------------
	logic off;
	logic clm;
	logic clear_req;

	panel_if pif ();

	// control panel over serial
	panel_ctrl panel_ctrl_inst (
		.CLK_EXT(CLK_EXT),
		.reset(reset),
		.rxd(rxd),
		.txd(txd),
		.clear_req(clear_req),
		.pif(pif)
	);

	// power supply and clear
	power_seq power_seq_inst (
		.CLK_EXT(CLK_EXT),
		.reset(reset),
		.clear_req(clear_req),
		.off(off),
		.pon(pon),
		.clo(clo),
		.clm(clm)
	);

	cpu_core cpu_core_inst (
		.CLK_EXT(CLK_EXT),
		.reset(reset),
		.off(off),
		.clo(clo),
		.clm(clm),
		.pif(pif)
	);

endmodule

// File: mera_top_sva.sv
`timescale 1ns/1ps

module mera_top_sva import mera_pkg::*; (
	input logic CLK_EXT,
	input logic reset,
	input logic pon,
	input logic clo,
	input logic clm,
	input logic clear_req,
	input logic strobe,
	input logic busy
);

	// power-up is over once pon was seen
	logic seen_pon;
	// consecutive cycles of clo so far
	int clo_len;
	bit fail_on = 1'b0;
	bit fail_gate = 1'b0;
	bit fail_len = 1'b0;
	bit fail_strobe = 1'b0;
	logic any_fail;

	assign any_fail = fail_on | fail_gate | fail_len | fail_strobe;

	always_ff @(posedge CLK_EXT) begin
		if (reset)
			seen_pon <= 1'b0;
		else if (pon)
			seen_pon <= 1'b1;
	end

	always_ff @(posedge CLK_EXT) begin
		if (reset || !clo)
			clo_len <= 0;
		else
			clo_len <= clo_len + 1;
	end

	// ----------------------------------------
	// sequencer and panel rules
	// ----------------------------------------
	// never back to unpowered
	assert property (@(posedge CLK_EXT) disable iff (reset) seen_pon |-> (pon || clo))
		else begin
			$error("pon and clo both low after power-up");
			fail_on = 1'b1;
		end

	// operator clear only from S_ON, which is pon high and clo low
	assert property (@(posedge CLK_EXT) disable iff (reset)
		($rose(clo) && !clm) |-> $past(clear_req && pon && !clo))
		else begin
			$error("clo raised by a clear request outside S_ON");
			fail_gate = 1'b1;
		end

	// power-up sweep excluded, it ends with clm
	assert property (@(posedge CLK_EXT) disable iff (reset)
		($fell(clo) && !$past(clm)) |-> (clo_len == CLR_CYCLES))
		else begin
			$error("clo pulse length differs from CLR_CYCLES");
			fail_len = 1'b1;
		end

	assert property (@(posedge CLK_EXT) disable iff (reset) !(strobe && busy))
		else begin
			$error("strobe high while busy");
			fail_strobe = 1'b1;
		end

endmodule

bind mera_top mera_top_sva sva_inst (
	.CLK_EXT(CLK_EXT),
	.reset(reset),
	.pon(pon),
	.clo(clo),
	.clm(clm),
	.clear_req(clear_req),
	.strobe(pif.strobe),
	.busy(pif.busy)
);

// File: tb_mera_top.sv
`timescale 1ns/1ps

module tb_mera_top import mera_pkg::*; ();

	localparam int MIX_OPS = 150;
	localparam int DIRECTED_CMDS = 250;
	// worst command is five bytes of ten bits plus busy slack
	localparam int CMD_CYCLES = 5 * 10 * UART_DIV + 20;
	localparam int POWER_CYCLES = 16 + OFF_CYCLES + MEM_WORDS;
	localparam int LIMIT_CYCLES = (DIRECTED_CMDS + MIX_OPS) * CMD_CYCLES + POWER_CYCLES;

	logic CLK_EXT;
	logic reset;
	logic rxd;
	logic txd;
	logic pon;
	logic clo;

	logic [31:0] rng;

	// ----------------------------------------
	// reference model state
	// ----------------------------------------
	word_t m_r [8];
	word_t m_ic;
	word_t m_ar;
	word_t m_mem [MEM_WORDS];
	word_t m_keys;
	word_t m_fetched;
	logic [3:0] m_sel;
	// fetched word on display
	logic m_show;

	mera_top mera_top_inst (
		.CLK_EXT(CLK_EXT),
		.reset(reset),
		.rxd(rxd),
		.txd(txd),
		.pon(pon),
		.clo(clo)
	);

	always #20 CLK_EXT = ~CLK_EXT;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// watchdog sized from command count and power-up
	initial begin
		repeat (LIMIT_CYCLES) @(posedge CLK_EXT);
		stop_run("run timed out before all tests finished");
	end

	// bound checker flags end the run at once
	initial begin
		@(posedge mera_top_inst.sva_inst.any_fail);
		stop_run("a bound assertion on mera_top failed during the run");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic logic [31:0] rand_next();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic word_t rand_word();
		logic [31:0] v;
		v = rand_next();
		return v[15:0];
	endfunction

	// what the panel should show right now
	function automatic word_t exp_display();
		if (m_show)
			return m_fetched;
		if (m_sel <= REG_R7)
			return m_r[m_sel[2:0]];
		if (m_sel == REG_IC)
			return m_ic;
		if (m_sel == REG_AR)
			return m_ar;
		// unused codes
		return '0;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < 8; i++)
			m_r[i] = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			m_mem[i] = '0;
		m_ic = '0;
		m_ar = '0;
		m_keys = '0;
		m_fetched = '0;
		m_sel = REG_R0;
		m_show = 1'b0;
	endtask

	// ----------------------------------------
	// serial driver and monitor
	// ----------------------------------------
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		// stop, data lsb first, start
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge CLK_EXT);
			#1 rxd = frame[i];
			repeat (UART_DIV - 1) @(posedge CLK_EXT);
		end
	endtask

	task automatic recv_byte(output logic [7:0] b);
		@(negedge CLK_EXT);
		while (txd)
			@(negedge CLK_EXT);
		// half a bit on is the middle of the start bit
		repeat (UART_DIV / 2) @(negedge CLK_EXT);
		assert (txd == 1'b0)
			else stop_run("start bit on txd did not last to its middle");
		for (int i = 0; i < 8; i++) begin
			repeat (UART_DIV) @(negedge CLK_EXT);
			b[i] = txd;
		end
		repeat (UART_DIV) @(negedge CLK_EXT);
		assert (txd == 1'b1)
			else stop_run("stop bit on txd was low");
	endtask

	// ----------------------------------------
	// panel commands with the model following each one
	// ----------------------------------------
	task automatic cmd_keys(input word_t k);
		send_byte(OP_KEYS);
		send_byte(k[15:8]);
		send_byte(k[7:0]);
		m_keys = k;
	endtask

	task automatic cmd_select(input logic [3:0] s);
		logic [31:0] v;
		v = rand_next();
		send_byte(OP_SELECT);
		// upper nibble ignored by the panel
		send_byte({v[7:4], s});
		m_sel = s;
	endtask

	task automatic cmd_load();
		send_byte(OP_LOAD);
		if (m_sel <= REG_R7)
			m_r[m_sel[2:0]] = m_keys;
		else if (m_sel == REG_IC)
			m_ic = m_keys;
		else if (m_sel == REG_AR)
			m_ar = m_keys;
		m_show = 1'b0;
	endtask

	task automatic cmd_store();
		send_byte(OP_STORE);
		m_mem[m_ar[MEM_AW-1:0]] = m_keys;
		m_ar = m_ar + 16'd1;
		m_show = 1'b0;
	endtask

	task automatic cmd_fetch();
		send_byte(OP_FETCH);
		m_fetched = m_mem[m_ar[MEM_AW-1:0]];
		m_ar = m_ar + 16'd1;
		m_show = 1'b1;
	endtask

	task automatic cmd_step();
		send_byte(OP_STEP);
		m_ic = m_ic + 16'd1;
		m_show = 1'b0;
	endtask

	// memory, keys and select survive a clear
	task automatic cmd_clear();
		send_byte(OP_CLEAR);
		for (int i = 0; i < 8; i++)
			m_r[i] = '0;
		m_ic = '0;
		m_ar = '0;
		m_show = 1'b0;
	endtask

	// displayed word sent back by a READ
	task automatic read_word(output word_t got);
		logic [7:0] hi;
		logic [7:0] lo;
		// monitor runs alongside since the reply may start before the stop bit ends
		fork
			send_byte(OP_READ);
			begin
				recv_byte(hi);
				recv_byte(lo);
			end
		join
		got = {hi, lo};
	endtask

	task automatic read_check();
		word_t exp;
		word_t got;
		exp = exp_display();
		read_word(got);
		assert (got == exp)
			else stop_run($sformatf("FAIL w got %h expected %h sel %h", got, exp, m_sel));
		assert (pon == 1'b1)
			else stop_run($sformatf("FAIL pon got %h expected 1", pon));
	endtask

	// ----------------------------------------
	// pulse length checks at the top ports
	// ----------------------------------------
	task automatic powerup_check();
		int n;
		n = 0;
		@(negedge CLK_EXT);
		// off phase has both low
		while (!clo && !pon) begin
			n++;
			@(negedge CLK_EXT);
		end
		assert (n == OFF_CYCLES)
			else stop_run($sformatf("FAIL off cycles got %h expected %h", n, OFF_CYCLES));
		n = 0;
		// memory sweep
		while (clo && !pon) begin
			n++;
			@(negedge CLK_EXT);
		end
		assert (n == MEM_WORDS)
			else stop_run($sformatf("FAIL clo cycles got %h expected %h", n, MEM_WORDS));
		assert (pon == 1'b1 && clo == 1'b0)
			else stop_run($sformatf("FAIL pon got %h clo got %h expected 1 and 0", pon, clo));
	endtask

	task automatic clear_check();
		int n;
		n = 0;
		fork
			cmd_clear();
			begin
				@(negedge CLK_EXT);
				while (!clo)
					@(negedge CLK_EXT);
				while (clo) begin
					n++;
					assert (pon == 1'b1)
						else stop_run($sformatf("FAIL pon got %h expected 1", pon));
					@(negedge CLK_EXT);
				end
			end
		join
		assert (n == CLR_CYCLES)
			else stop_run($sformatf("FAIL clo cycles got %h expected %h", n, CLR_CYCLES));
	endtask

	initial begin
		logic [31:0] x;
		word_t k;
		word_t start;
		word_t got;
		int n_words;
		int n_steps;
		CLK_EXT = 1'b0;
		reset = 1'b1;
		rxd = 1'b1;
		rng = 32'd70647;
		model_reset();
		repeat (16) @(posedge CLK_EXT);
		#1 reset = 1'b0;
		powerup_check();

		// random register loads and readback of every code
		for (int i = 0; i < 10; i++) begin
			cmd_keys(rand_word());
			cmd_select(4'(rand_next() % 10));
			cmd_load();
			cmd_select(4'(rand_next() % 16));
			read_check();
		end
		for (int i = 0; i < 16; i++) begin
			cmd_select(4'(i));
			read_check();
		end

		// memory run through AR
		start = rand_word();
		n_words = 4 + int'(rand_next() % 5);
		cmd_keys(start);
		cmd_select(REG_AR);
		cmd_load();
		for (int i = 0; i < n_words; i++) begin
			cmd_keys(rand_word());
			cmd_store();
		end
		cmd_keys(start);
		cmd_load();
		for (int i = 0; i < n_words; i++) begin
			cmd_fetch();
			read_check();
		end
		// ignored load drops the fetched word from display
		cmd_select(4'd12);
		cmd_load();
		cmd_select(REG_AR);
		read_word(got);
		assert (got == start + word_t'(n_words))
			else stop_run($sformatf("FAIL ar got %h expected %h", got,
				start + word_t'(n_words)));

		// steps from near the top so the count wraps
		x = rand_next();
		k = {12'hFFF, x[3:0]};
		n_steps = 1 + int'(rand_next() % 24);
		cmd_keys(k);
		cmd_select(REG_IC);
		cmd_load();
		for (int i = 0; i < n_steps; i++)
			cmd_step();
		read_word(got);
		assert (got == k + word_t'(n_steps))
			else stop_run($sformatf("FAIL ic got %h expected %h", got,
				k + word_t'(n_steps)));

		// clear keeps memory
		clear_check();
		for (int i = 0; i < 10; i++) begin
			cmd_select(4'(i));
			read_check();
		end
		cmd_keys(start);
		cmd_select(REG_AR);
		cmd_load();
		for (int i = 0; i < n_words; i++) begin
			cmd_fetch();
			read_check();
		end

		// ----------------------------------------
		// random mix
		// ----------------------------------------
		for (int i = 0; i < MIX_OPS; i++) begin
			x = rand_next();
			case (x % 10)
				0: cmd_keys(rand_word());
				1: cmd_select(x[7:4]);
				2: cmd_load();
				3: cmd_store();
				4: cmd_fetch();
				5: cmd_step();
				6: cmd_clear();
				// bit 7 set is never an opcode
				7: send_byte(x[15:8] | 8'h80);
				default: read_check();
			endcase
		end
		read_check();

		if (mera_top_inst.sva_inst.any_fail == 1'b0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			stop_run("a bound assertion on mera_top failed during the run");
		end
	end

endmodule

// File: filelist.f
mera_pkg.sv
panel_if.sv
uart_rx.sv
uart_tx.sv
panel_ctrl.sv
power_seq.sv
cpu_core.sv
mera_top.sv
mera_top_sva.sv
tb_mera_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mera_top
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log
# keep running after an assertion error so the testbench can report it
SIM_ARGS  = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
